// File: logic/mbox_pkg.sv
// mailbox package: widths, fifo depth, register map, bit positions and fixed read values
package mbox_pkg;

  // --------------------
  // widths and depth
  // --------------------
  localparam int unsigned DATA_W     = 32;                  // mailbox word width
  localparam int unsigned MBOX_DEPTH = 8;                   // words per direction
  localparam int unsigned USAGE_W    = 4;                   // msb set means full
  localparam int unsigned PTR_W      = $clog2(MBOX_DEPTH);  // fifo pointer, wraps naturally
  localparam int unsigned REG_IDX_W  = 4;                   // register index on the bus

  // field widths of the narrow registers
  localparam int unsigned ST_W   = 4;
  localparam int unsigned IRQ_W  = 3;
  localparam int unsigned ERR_W  = 2;
  localparam int unsigned CTRL_W = 2;

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [USAGE_W-1:0]   usage_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // register map, one index per 32-bit register
  typedef enum reg_idx_t {
    MBOXW  = 4'd0,  // push into outgoing fifo
    MBOXR  = 4'd1,  // pop from incoming fifo
    STATUS = 4'd2,  // read only
    ERROR  = 4'd3,  // clear on read
    WIRQT  = 4'd4,  // write threshold
    RIRQT  = 4'd5,  // read threshold
    IRQS   = 4'd6,  // irq status, write 1 to ack
    IRQEN  = 4'd7,  // irq enable
    IRQP   = 4'd8,  // pending, read only
    CTRL   = 4'd9   // flush strobes
  } reg_e;

  // fixed read values
  localparam data_t MBOXW_READ_VAL = 32'hFEEDC0DE;  // write-only register read back
  localparam data_t EMPTY_READ_VAL = 32'hFEEDDEAD;  // pop from empty fifo

  // status bits
  localparam int unsigned ST_RD_EMPTY = 0;
  localparam int unsigned ST_WR_FULL  = 1;
  localparam int unsigned ST_WR_THR   = 2;
  localparam int unsigned ST_RD_THR   = 3;
  // irq bits, shared by IRQS, IRQEN and IRQP
  localparam int unsigned IRQ_WR  = 0;
  localparam int unsigned IRQ_RD  = 1;
  localparam int unsigned IRQ_ERR = 2;
  // error bits
  localparam int unsigned ERR_RD_EMPTY = 0;
  localparam int unsigned ERR_WR_FULL  = 1;
  // control bits
  localparam int unsigned CTRL_FLUSH_WR = 0;
  localparam int unsigned CTRL_FLUSH_RD = 1;

endpackage

// File: logic/mbox_fifo.sv
// mailbox fifo: one direction word buffer with occupancy count and flush from both ends
`timescale 1ns/10ps

module mbox_fifo (
  input  logic             clk_i,
  input  logic             arst_n_i,
  // sending side
  input  logic             push_i,      // guarded by sender against full
  input  mbox_pkg::data_t  wdata_i,
  // receiving side
  input  logic             pop_i,       // guarded by receiver against empty
  output mbox_pkg::data_t  rdata_o,     // head word, not fall-through
  // flush requests
  input  logic             wr_flush_i,  // from the sending port
  input  logic             rd_flush_i,  // from the receiving port
  output mbox_pkg::usage_t usage_o      // seen by both ports
);
  import mbox_pkg::*;

  logic [PTR_W-1:0] wr_ptr_q;  // next free slot
  logic [PTR_W-1:0] rd_ptr_q;  // current head
  usage_t           usage_q;   // words stored, reaches MBOX_DEPTH
  data_t            mem_q [MBOX_DEPTH];
  logic             flush;

  // either side may empty the buffer
  assign flush = wr_flush_i | rd_flush_i;

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush) begin
      // flush wins over a push or pop in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: usage_q <= usage_q;  // idle, or push and pop together
      endcase
    end
  end

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (push_i && !flush) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  assign rdata_o = mem_q[rd_ptr_q];  // valid while usage is non-zero
  assign usage_o = usage_q;

endmodule

// File: logic/mbox_port_regs.sv
// mailbox port: register bank behind a request/response bus, fifo control and level irq
`timescale 1ns/10ps

module mbox_port_regs (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // request side
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  logic               req_write_i,
  input  mbox_pkg::reg_idx_t req_idx_i,
  input  mbox_pkg::data_t    req_wdata_i,
  // response side
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output mbox_pkg::data_t    rsp_rdata_o,
  output logic               rsp_err_o,
  // outgoing fifo
  output logic               out_push_o,
  output mbox_pkg::data_t    out_wdata_o,
  input  mbox_pkg::usage_t   out_usage_i,
  // incoming fifo
  output logic               in_pop_o,
  input  mbox_pkg::data_t    in_rdata_i,
  input  mbox_pkg::usage_t   in_usage_i,
  // flush strobes
  output logic               out_flush_o,
  output logic               in_flush_o,
  // level interrupt, active high
  output logic               irq_o
);
  import mbox_pkg::*;

  // response register
  logic              rsp_valid_q;
  data_t             rsp_rdata_q;
  logic              rsp_err_q;
  logic              req_fire;      // request accepted this cycle
  data_t             rd_data;       // next response data
  logic              rd_err;        // next response error flag

  // register bank with next-state signals in _d
  logic [ERR_W-1:0]  error_q, error_d;
  usage_t            wirqt_q, wirqt_d;
  usage_t            rirqt_q, rirqt_d;
  logic [IRQ_W-1:0]  irqs_q,  irqs_d;
  logic [IRQ_W-1:0]  irqen_q, irqen_d;
  logic              irq_q;

  // built from other state
  logic [ST_W-1:0]   status;
  logic [IRQ_W-1:0]  irqp;
  logic              out_full;
  logic              in_empty;
  logic              ctrl_wr;

  // clamp a written threshold so the irq can still fire on a full fifo
  function automatic usage_t clamp_thr(data_t val);
    usage_t res;
    if (val >= data_t'(MBOX_DEPTH)) begin
      res = usage_t'(MBOX_DEPTH - 1);
    end else begin
      res = usage_t'(val);
    end
    return res;
  endfunction

  // --------------------
  // handshake
  // --------------------
  assign req_ready_o = ~rsp_valid_q;               // one request in flight
  assign req_fire    = req_valid_i & req_ready_o;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

  // --------------------
  // derived state
  // --------------------
  assign out_full = (out_usage_i == usage_t'(MBOX_DEPTH));
  assign in_empty = (in_usage_i == '0);

  assign status[ST_RD_EMPTY] = in_empty;
  assign status[ST_WR_FULL]  = out_full;
  assign status[ST_WR_THR]   = out_usage_i > wirqt_q;  // strict compare
  assign status[ST_RD_THR]   = in_usage_i > rirqt_q;

  assign irqp = irqs_q & irqen_q;  // pending = status masked by enable

  // flush strobes last only for the accepted CTRL write
  assign ctrl_wr     = req_fire & req_write_i & (reg_e'(req_idx_i) == CTRL);
  assign out_flush_o = ctrl_wr & req_wdata_i[CTRL_FLUSH_WR];
  assign in_flush_o  = ctrl_wr & req_wdata_i[CTRL_FLUSH_RD];

  assign out_wdata_o = req_wdata_i;  // pushed only with out_push_o

  // --------------------
  // request decode
  // --------------------
  always_comb begin
    rd_data    = '0;  // writes and errors return zero
    rd_err     = 1'b0;
    out_push_o = 1'b0;
    in_pop_o   = 1'b0;
    error_d    = error_q;
    wirqt_d    = wirqt_q;
    rirqt_d    = rirqt_q;
    irqs_d     = irqs_q;
    irqen_d    = irqen_q;

    if (req_fire) begin
      case (reg_e'(req_idx_i))
        MBOXW: begin
          if (!req_write_i) begin
            rd_data = MBOXW_READ_VAL;
          end else if (!out_full) begin
            out_push_o = 1'b1;
          end else begin
            // full write, word dropped
            rd_err               = 1'b1;
            error_d[ERR_WR_FULL] = 1'b1;
            irqs_d[IRQ_ERR]      = 1'b1;
          end
        end
        MBOXR: begin
          if (req_write_i) begin
            rd_err = 1'b1;  // read only
          end else if (!in_empty) begin
            in_pop_o = 1'b1;
            rd_data  = in_rdata_i;  // head captured as it leaves
          end else begin
            rd_data               = EMPTY_READ_VAL;
            rd_err                = 1'b1;
            error_d[ERR_RD_EMPTY] = 1'b1;
            irqs_d[IRQ_ERR]       = 1'b1;
          end
        end
        STATUS: begin
          rd_err  = req_write_i;
          rd_data = req_write_i ? '0 : data_t'(status);
        end
        ERROR: begin
          if (req_write_i) begin
            rd_err = 1'b1;
          end else begin
            rd_data = data_t'(error_q);
            error_d = '0;  // clear on read
          end
        end
        WIRQT: begin
          if (req_write_i) wirqt_d = clamp_thr(req_wdata_i);
          else             rd_data = data_t'(wirqt_q);
        end
        RIRQT: begin
          if (req_write_i) rirqt_d = clamp_thr(req_wdata_i);
          else             rd_data = data_t'(rirqt_q);
        end
        IRQS: begin
          if (req_write_i) irqs_d  = irqs_q & ~req_wdata_i[IRQ_W-1:0];  // write 1 to ack
          else             rd_data = data_t'(irqs_q);
        end
        IRQEN: begin
          if (req_write_i) irqen_d = req_wdata_i[IRQ_W-1:0];
          else             rd_data = data_t'(irqen_q);
        end
        IRQP: begin
          rd_err  = req_write_i;
          rd_data = req_write_i ? '0 : data_t'(irqp);
        end
        CTRL: begin
          // flush itself comes from ctrl_wr above and the strobes read back as zero
        end
        default: rd_err = 1'b1;  // unmapped index
      endcase
    end

    // a live threshold condition beats an ack in the same cycle
    if (status[ST_WR_THR]) irqs_d[IRQ_WR] = 1'b1;
    if (status[ST_RD_THR]) irqs_d[IRQ_RD] = 1'b1;
  end

  // --------------------
  // state
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
      error_q     <= '0;
      wirqt_q     <= '0;
      rirqt_q     <= '0;
      irqs_q      <= '0;
      irqen_q     <= '0;
      irq_q       <= 1'b0;
    end else begin
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;  // response taken
      end
      error_q <= error_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
      irq_q   <= |irqp;  // one cycle behind irqs/irqen
    end
  end

  // response payload, held until the next accepted request
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_rdata_q <= rd_data;
      rsp_err_q   <= rd_err;
    end
  end

  assign irq_o = irq_q;

endmodule

// File: logic/mbox_top.sv
// mailbox top: two register ports joined by two opposite fifos
`timescale 1ns/10ps

module mbox_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // port 0 bus
  input  logic               port0_req_valid_i,
  output logic               port0_req_ready_o,
  input  logic               port0_req_write_i,
  input  mbox_pkg::reg_idx_t port0_req_idx_i,
  input  mbox_pkg::data_t    port0_req_wdata_i,
  output logic               port0_rsp_valid_o,
  input  logic               port0_rsp_ready_i,
  output mbox_pkg::data_t    port0_rsp_rdata_o,
  output logic               port0_rsp_err_o,
  output logic               port0_irq_o,
  // port 1 bus
  input  logic               port1_req_valid_i,
  output logic               port1_req_ready_o,
  input  logic               port1_req_write_i,
  input  mbox_pkg::reg_idx_t port1_req_idx_i,
  input  mbox_pkg::data_t    port1_req_wdata_i,
  output logic               port1_rsp_valid_o,
  input  logic               port1_rsp_ready_i,
  output mbox_pkg::data_t    port1_rsp_rdata_o,
  output logic               port1_rsp_err_o,
  output logic               port1_irq_o
);
  import mbox_pkg::*;

  // 0 to 1 direction
  logic   push_0to1, pop_0to1;
  data_t  wdata_0to1, rdata_0to1;
  usage_t usage_0to1;
  logic   wflush_0to1, rflush_0to1;  // from port 0 / port 1
  // 1 to 0 direction
  logic   push_1to0, pop_1to0;
  data_t  wdata_1to0, rdata_1to0;
  usage_t usage_1to0;
  logic   wflush_1to0, rflush_1to0;  // from port 1 / port 0

  mbox_port_regs u_port0 (
    .clk_i,
    .arst_n_i,
    .req_valid_i ( port0_req_valid_i ),
    .req_ready_o ( port0_req_ready_o ),
    .req_write_i ( port0_req_write_i ),
    .req_idx_i   ( port0_req_idx_i   ),
    .req_wdata_i ( port0_req_wdata_i ),
    .rsp_valid_o ( port0_rsp_valid_o ),
    .rsp_ready_i ( port0_rsp_ready_i ),
    .rsp_rdata_o ( port0_rsp_rdata_o ),
    .rsp_err_o   ( port0_rsp_err_o   ),
    .out_push_o  ( push_0to1         ),  // port 0 sends
    .out_wdata_o ( wdata_0to1        ),
    .out_usage_i ( usage_0to1        ),
    .in_pop_o    ( pop_1to0          ),  // port 0 receives
    .in_rdata_i  ( rdata_1to0        ),
    .in_usage_i  ( usage_1to0        ),
    .out_flush_o ( wflush_0to1       ),
    .in_flush_o  ( rflush_1to0       ),
    .irq_o       ( port0_irq_o       )
  );

  mbox_port_regs u_port1 (
    .clk_i,
    .arst_n_i,
    .req_valid_i ( port1_req_valid_i ),
    .req_ready_o ( port1_req_ready_o ),
    .req_write_i ( port1_req_write_i ),
    .req_idx_i   ( port1_req_idx_i   ),
    .req_wdata_i ( port1_req_wdata_i ),
    .rsp_valid_o ( port1_rsp_valid_o ),
    .rsp_ready_i ( port1_rsp_ready_i ),
    .rsp_rdata_o ( port1_rsp_rdata_o ),
    .rsp_err_o   ( port1_rsp_err_o   ),
    .out_push_o  ( push_1to0         ),
    .out_wdata_o ( wdata_1to0        ),
    .out_usage_i ( usage_1to0        ),
    .in_pop_o    ( pop_0to1          ),
    .in_rdata_i  ( rdata_0to1        ),
    .in_usage_i  ( usage_0to1        ),
    .out_flush_o ( wflush_1to0       ),
    .in_flush_o  ( rflush_0to1       ),
    .irq_o       ( port1_irq_o       )
  );

  mbox_fifo u_fifo_0to1 (
    .clk_i,
    .arst_n_i,
    .push_i     ( push_0to1   ),
    .wdata_i    ( wdata_0to1  ),
    .pop_i      ( pop_0to1    ),
    .rdata_o    ( rdata_0to1  ),
    .wr_flush_i ( wflush_0to1 ),
    .rd_flush_i ( rflush_0to1 ),
    .usage_o    ( usage_0to1  )
  );

  mbox_fifo u_fifo_1to0 (
    .clk_i,
    .arst_n_i,
    .push_i     ( push_1to0   ),
    .wdata_i    ( wdata_1to0  ),
    .pop_i      ( pop_1to0    ),
    .rdata_o    ( rdata_1to0  ),
    .wr_flush_i ( wflush_1to0 ),
    .rd_flush_i ( rflush_1to0 ),
    .usage_o    ( usage_1to0  )
  );

endmodule

// File: test/mbox_assert.sv
// port checker: response hold under back-pressure, one request in flight, no push when full
`timescale 1ns/10ps

module mbox_assert (
  input logic             clk_i,
  input logic             arst_n_i,
  input logic             rsp_valid_i,
  input logic             rsp_ready_i,
  input mbox_pkg::data_t  rsp_rdata_i,
  input logic             rsp_err_i,
  input logic             out_push_i,
  input mbox_pkg::usage_t out_usage_i
);
  import mbox_pkg::*;

  int hit_cnt = 0;  // failed checks, read by the testbench

  // --------------------
  // response channel
  // --------------------
  property rsp_hold_p;
    @(posedge clk_i) disable iff (!arst_n_i)
      (rsp_valid_i && !rsp_ready_i) |=>
        (rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i));
  endproperty

  rsp_hold_a: assert property (rsp_hold_p)
    else begin
      hit_cnt++;
      $error("response moved while rsp_ready was low");
    end

  // no request slips in while one is answered, so nothing gets pushed
  one_req_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                              rsp_valid_i |-> !out_push_i)
    else begin
      hit_cnt++;
      $error("request taken with a response pending");
    end

  // --------------------
  // outgoing fifo
  // --------------------
  no_full_push_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                   (out_usage_i == usage_t'(MBOX_DEPTH)) |-> !out_push_i)
    else begin
      hit_cnt++;
      $error("push into a full fifo");
    end

endmodule

// File: test/mbox_tb.sv
// mailbox testbench: golden-file driven register accesses on both ports with random back-pressure
`timescale 1ns/10ps

module mbox_tb;
  import mbox_pkg::*;

  localparam int WAIT_MAX = 50;  // cycles allowed per wait loop

  logic     clk;
  logic     arst_n;
  logic     req_valid [2];
  logic     req_ready [2];
  logic     req_write [2];
  reg_idx_t req_idx   [2];
  data_t    req_wdata [2];
  logic     rsp_valid [2];
  logic     rsp_ready [2];
  data_t    rsp_rdata [2];
  logic     rsp_err   [2];
  logic     irq       [2];

  int       pass_cnt;
  int       fail_cnt;
  int       test_errs;   // mismatches in the running test
  logic     timed_out;

  mbox_top DUT (
    .clk_i             ( clk          ),
    .arst_n_i          ( arst_n       ),
    .port0_req_valid_i ( req_valid[0] ),
    .port0_req_ready_o ( req_ready[0] ),
    .port0_req_write_i ( req_write[0] ),
    .port0_req_idx_i   ( req_idx[0]   ),
    .port0_req_wdata_i ( req_wdata[0] ),
    .port0_rsp_valid_o ( rsp_valid[0] ),
    .port0_rsp_ready_i ( rsp_ready[0] ),
    .port0_rsp_rdata_o ( rsp_rdata[0] ),
    .port0_rsp_err_o   ( rsp_err[0]   ),
    .port0_irq_o       ( irq[0]       ),
    .port1_req_valid_i ( req_valid[1] ),
    .port1_req_ready_o ( req_ready[1] ),
    .port1_req_write_i ( req_write[1] ),
    .port1_req_idx_i   ( req_idx[1]   ),
    .port1_req_wdata_i ( req_wdata[1] ),
    .port1_rsp_valid_o ( rsp_valid[1] ),
    .port1_rsp_ready_i ( rsp_ready[1] ),
    .port1_rsp_rdata_o ( rsp_rdata[1] ),
    .port1_rsp_err_o   ( rsp_err[1]   ),
    .port1_irq_o       ( irq[1]       )
  );

  // checkers on both port blocks
  bind mbox_port_regs mbox_assert u_assert (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .rsp_valid_i ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_rdata_i ( rsp_rdata_o ),
    .rsp_err_i   ( rsp_err_o   ),
    .out_push_i  ( out_push_o  ),
    .out_usage_i ( out_usage_i )
  );

  always #20 clk = ~clk;  // 40 ns period

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("error %s: data expected %h, actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("error %s: err flag expected %b, actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_irq(input string name, input int port, input logic exp, input logic act);
    if (exp !== act) begin
      $display("error %s: irq of port %0d expected %b, actual %b", name, port, exp, act);
      test_errs++;
    end
  endtask

  // --------------------
  // bus access
  // --------------------
  task automatic wait_req_ready(input int port);
    int cnt;
    cnt = 0;
    @(negedge clk);  // outputs settled here
    while (req_ready[port] !== 1'b1 && !timed_out) begin
      cnt++;
      if (cnt > WAIT_MAX) begin
        $display("port %0d never became ready for a request", port);
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  task automatic wait_rsp_valid(input int port);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (rsp_valid[port] !== 1'b1 && !timed_out) begin
      cnt++;
      if (cnt > WAIT_MAX) begin
        $display("no response from port %0d", port);
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  // one request, then a randomly delayed response accept
  task automatic access(input int port, input logic write, input reg_idx_t idx,
                        input data_t wdata, output data_t rdata, output logic err);
    int hold;
    rdata = '0;
    err   = 1'b0;
    wait_req_ready(port);
    if (!timed_out) begin
      @(posedge clk);
      req_valid[port] <= 1'b1;
      req_write[port] <= write;
      req_idx[port]   <= idx;
      req_wdata[port] <= wdata;
      @(posedge clk);            // taken here, ready was high
      req_valid[port] <= 1'b0;
      wait_rsp_valid(port);
    end
    if (!timed_out) begin
      hold = int'($urandom % 6);  // 0 to 5 cycles of back-pressure
      repeat (hold) @(negedge clk);
      rdata = rsp_rdata[port];
      err   = rsp_err[port];
      @(posedge clk);
      rsp_ready[port] <= 1'b1;
      @(posedge clk);            // response leaves here
      rsp_ready[port] <= 1'b0;
    end
  endtask

  // one golden line holds name, port, op, idx, data and flag
  task automatic run_step(input string line);
    string    name;
    string    op;
    int       port;
    int       n;
    reg_idx_t idx;
    data_t    val;
    data_t    rdata;
    logic     flag;
    logic     err;
    test_errs = 0;
    n = $sscanf(line, "%s %d %s %h %h %h", name, port, op, idx, val, flag);
    if (n != 6 || port < 0 || port > 1) begin
      $display("malformed line in golden file: %s", line);
      fail_cnt++;
    end else begin
      if (op == "R") begin
        access(port, 1'b0, idx, '0, rdata, err);
        if (!timed_out) begin
          check_data(name, val, rdata);
          check_err(name, flag, err);
        end
      end else if (op == "W") begin
        access(port, 1'b1, idx, val, rdata, err);
        if (!timed_out) begin
          check_data(name, '0, rdata);  // writes answer with zero data
          check_err(name, flag, err);
        end
      end else if (op == "I") begin
        repeat (2) @(negedge clk);  // irq is registered behind IRQS
        check_irq(name, 0, val[0], irq[0]);
        check_irq(name, 1, flag, irq[1]);
      end else begin
        $display("unknown operation %s in test %s", op, name);
        test_errs++;
      end
      if (timed_out) test_errs++;
      if (test_errs == 0) begin
        pass_cnt++;
        $display("pass %s", name);
      end else begin
        fail_cnt++;
        $display("fail %s", name);
      end
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int    fd;
    int    n;
    int    hits;
    string line;
    void'($urandom(32'h9754_596e));
    clk       = 1'b0;
    arst_n    = 1'b0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    timed_out = 1'b0;
    for (int p = 0; p < 2; p++) begin
      req_valid[p] = 1'b0;
      req_write[p] = 1'b0;
      req_idx[p]   = '0;
      req_wdata[p] = '0;
      rsp_ready[p] = 1'b0;
    end
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    fd = $fopen("test/mbox_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/mbox_golden.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          run_step(line);
        end
      end
      $fclose(fd);
    end

    hits = DUT.u_port0.u_assert.hit_cnt + DUT.u_port1.u_assert.hit_cnt;
    $display("tests passed %0d, failed %0d, assertion failures %0d", pass_cnt, fail_cnt, hits);
    if (fail_cnt == 0 && hits == 0 && pass_cnt > 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: test/mbox_golden.txt
# columns: test_name port op idx data flag (idx, data, flag in hex)
# op R reads and W writes, flag is the expected error; op I checks irq, data = port 0, flag = port 1
b1_push0_a 0 W 0 11111111 0
b1_push0_b 0 W 0 22222222 0
b1_push0_c 0 W 0 33333333 0
b1_pop1_a 1 R 1 11111111 0
b1_pop1_b 1 R 1 22222222 0
b1_pop1_c 1 R 1 33333333 0
b1_push1_a 1 W 0 a5a5a5a5 0
b1_push1_b 1 W 0 5a5a5a5a 0
b1_pop0_a 0 R 1 a5a5a5a5 0
b1_pop0_b 0 R 1 5a5a5a5a 0
b1_mboxw_rd 0 R 0 feedc0de 0
b2_empty1 1 R 1 feeddead 1
b2_fill_0 0 W 0 00000010 0
b2_fill_1 0 W 0 00000011 0
b2_fill_2 0 W 0 00000012 0
b2_fill_3 0 W 0 00000013 0
b2_fill_4 0 W 0 00000014 0
b2_fill_5 0 W 0 00000015 0
b2_fill_6 0 W 0 00000016 0
b2_fill_7 0 W 0 00000017 0
b2_full 0 W 0 deadbeef 1
b2_empty0 0 R 1 feeddead 1
b2_err_both 0 R 3 00000003 0
b2_err_clr 0 R 3 00000000 0
b3_st_full 0 R 2 00000007 0
b3_wirqt 0 W 4 00000064 0
b3_wirqt_rd 0 R 4 00000007 0
b3_pop 1 R 1 00000010 0
b3_st_below 0 R 2 00000001 0
b3_st_port1 1 R 2 00000008 0
b4_irq_off 0 I 0 00000000 0
b4_ack_all 0 W 6 00000007 0
b4_en 0 W 7 00000001 0
b4_push 0 W 0 00000099 0
b4_irq_high 0 I 0 00000001 0
b4_irqp 0 R 8 00000001 0
b4_ack_busy 0 W 6 00000001 0
b4_irq_held 0 I 0 00000001 0
b4_pop 1 R 1 00000011 0
b4_ack_done 0 W 6 00000001 0
b4_irq_gone 0 I 0 00000000 0
b5_flush 0 W 9 00000001 0
b5_st_port1 1 R 2 00000001 0
b5_bad_idx 0 R f 00000000 1
b5_ro_write 1 W 2 00000000 1

// File: mailbox.f
logic/mbox_pkg.sv
logic/mbox_fifo.sv
logic/mbox_port_regs.sv
logic/mbox_top.sv
test/mbox_assert.sv
test/mbox_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = mbox_tb
FILELIST = mailbox.f
RUN_ARGS = +verilator+error+limit+100

BIN  = obj_dir/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
